//--- rtl/pr_pkg.sv
/*
	P-R register unit shared definitions
	Word and flag widths, L-bus and KI-bus source selection,
	R0 flag bit positions
*/

package pr_pkg;

	localparam int word_w    = 16;	// W, L and KI bus width
	localparam int flags_w   = 9;	// CPU flags ZMVCLEGYX in R0
	localparam int user_regs = 7;	// R1-R7, address 0 is R0

	// L bus source toward the ALU
	typedef enum logic [1:0] {
		l_r0,		// R0 in place
		l_user,		// One of R1-R7
		l_r0_high	// R0 shifted right 8
	} l_src_t;

	// KI bus source
	typedef enum logic [2:0] {
		ki_none,	// Bus idle, reads zero
		ki_rz,		// Interrupt request register
		ki_sr,		// RS, Q, BS and NB
		ki_rb,		// Binary load register
		ki_zp		// Data from the system bus
	} ki_src_t;

	// R0 flag bit positions, big-endian like W
	typedef enum logic [3:0] {
		f_z = 4'd0,	// Zero
		f_m = 4'd1,	// Minus
		f_v = 4'd2,	// Overflow
		f_c = 4'd3,	// Carry
		f_l = 4'd4,	// Less
		f_e = 4'd5,	// Equal
		f_g = 4'd6,	// Greater
		f_y = 4'd7,	// Shift extension
		f_x = 4'd8	// Extended carry
	} flag_t;

endpackage

//--- rtl/regs.sv
/*
	User register file R1-R7
	One write port from W and one asynchronous read port to L
*/

module regs (
	input  logic                      __clk,
	input  logic                      rst,
	input  logic [0:2]                addr,	// {rc, rb, ra}
	input  logic                      we,	// Strobe-qualified write
	input  logic [0:pr_pkg::word_w-1] w,
	output logic [0:pr_pkg::word_w-1] l
);

	import pr_pkg::*;

	logic [0:word_w-1] r [1:user_regs];	// R1..R7

	always_ff @(posedge __clk) begin
		if (rst) begin
			for (int i = 1; i <= user_regs; i++) begin
				r[i] <= '0;
			end
		end else if (we && (addr != 3'd0)) begin	// Address 0 belongs to R0
			r[addr] <= w;
		end
	end

	// Read side, address 0 is never routed here by the top level
	always_comb begin
		if (addr == 3'd0) begin
			l = '0;
		end else begin
			l = r[addr];
		end
	end

endmodule

//--- rtl/rb.sv
/*
	RB binary load register
	Filled from W in three independent field groups
*/

module rb (
	input  logic                      __clk,
	input  logic                      rst,
	input  logic [0:5]                w,		// W[10:15] from the top
	input  logic                      w_rba,	// Bits 10-15
	input  logic                      w_rbb,	// Bits 4-9
	input  logic                      w_rbc,	// Bits 0-3
	output logic [0:pr_pkg::word_w-1] rb
);

	always_ff @(posedge __clk) begin
		if (rst) begin
			rb <= '0;
		end else begin
			// Each group loads on its own, several may fire together
			if (w_rbc) begin
				rb[0:3] <= w[0:3];	// Short leading group
			end
			if (w_rbb) begin
				rb[4:9] <= w;	// Middle group
			end
			if (w_rba) begin
				rb[10:15] <= w;	// Tail group
			end
		end
	end

endmodule

//--- rtl/bar_regs.sv
/*
	NB, Q and BS system registers
	Loaded from W on a BAR write, gated onto the system bus drivers
*/

module bar_regs #(
	parameter int cpu_number = 0	// Selects PN driver polarity
) (
	input  logic       __clk,
	input  logic       rst,
	input  logic [0:3] w_nb,	// W[12:15]
	input  logic [0:1] w_qbs,	// W[10:11] as {Q, BS}
	input  logic       w_bar,
	input  logic       strob1,
	input  logic       clm,		// Clears NB and BS
	input  logic       zer,		// Clears Q
	input  logic       bar_nb,
	input  logic       q_nb,
	input  logic       rpn,
	input  logic       bp_nb,
	input  logic       pn_nb,
	output logic [0:3] nb,
	output logic       q,
	output logic       bs,
	output logic [0:3] dnb,
	output logic       dqb,
	output logic       dpn,
	output logic       zgpn
);

	localparam logic cpu_bit = 1'(cpu_number);

	logic cnb;	// BAR load enable
	logic pn_bs;	// BS seen through CPU polarity

	assign cnb = w_bar & strob1;

	always_ff @(posedge __clk) begin
		if (rst || clm) begin
			nb <= '0;
			bs <= 1'b0;
		end else if (cnb) begin
			nb <= w_nb;
			bs <= w_qbs[1];
		end
	end

	always_ff @(posedge __clk) begin
		if (rst || zer) begin	// Clear beats a load
			q <= 1'b0;
		end else if (cnb) begin
			q <= w_qbs[0];
		end
	end

	assign dnb   = nb & {4{bar_nb}};	// NB driver
	assign dqb   = q & q_nb;		// Q driver
	assign zgpn  = rpn ^ ~cpu_bit;
	assign pn_bs = cpu_bit ^ bs;
	assign dpn   = (pn_bs & bp_nb) | (cpu_bit & pn_nb);	// PN driver

endmodule

//--- rtl/r0.sv
/*
	R0 status register
	Nine CPU flags updated from ALU results or written from W,
	plus the user byte in bits 9-15
*/

module r0 (
	input  logic                       __clk,
	input  logic                       rst,
	input  logic [0:pr_pkg::word_w-1]  w,
	input  logic                       strob1,
	input  logic                       strob_b,	// LEG update, already gated by ust_leg
	input  logic                       w_zmvc,
	input  logic                       w_legy,
	input  logic                       w8_x,
	input  logic                       lrp,		// User byte write
	input  logic                       ust_z,
	input  logic                       ust_mc,
	input  logic                       ust_v,
	input  logic                       clr_v,
	input  logic                       ust_y,
	input  logic                       ust_x,
	input  logic                       zs,
	input  logic                       s0,
	input  logic                       s_1,
	input  logic                       carry,
	input  logic                       vl,
	input  logic                       vg,
	input  logic                       exy,
	input  logic                       exx,
	input  logic                       zer,
	output logic [0:pr_pkg::flags_w-1] flags,
	output logic [9:15]                user_byte
);

	import pr_pkg::*;

	logic ovf;	// Sign change seen by the ALU

	assign ovf = s0 ^ s_1;

	always_ff @(posedge __clk) begin
		if (rst) begin
			flags <= '0;
		end else begin
			// Z M V C
			if (w_zmvc) begin
				flags[f_z:f_c] <= w[0:3];	// W write wins
			end else if (strob1) begin
				if (ust_z) begin
					flags[f_z] <= zs;
				end
				if (ust_mc) begin
					flags[f_m] <= s0;
					flags[f_c] <= carry;
				end
				if (clr_v) begin
					flags[f_v] <= 1'b0;	// Clear beats set
				end else if (ust_v && ovf) begin
					flags[f_v] <= 1'b1;	// Sticky overflow
				end
			end

			// L E G Y
			if (w_legy) begin
				flags[f_l:f_y] <= w[4:7];
			end else begin
				if (strob_b) begin
					flags[f_l] <= vl;
					flags[f_e] <= zs;
					flags[f_g] <= vg;
				end
				if (strob1 && ust_y) begin
					flags[f_y] <= exy;
				end
			end

			// X
			if (w8_x) begin
				flags[f_x] <= w[8];
			end else if (strob1 && ust_x) begin
				flags[f_x] <= exx;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (rst || zer) begin	// zer takes the user byte too
			user_byte <= '0;
		end else if (lrp) begin
			user_byte <= w[9:15];
		end
	end

endmodule

//--- rtl/bus_ki.sv
/*
	KI bus source selection
	Picks RZ, SR, RB or ZP by kia/kib, zero when idle
*/

module bus_ki (
	input  logic                      kia,
	input  logic                      kib,
	input  logic [0:pr_pkg::word_w-1] rz,
	input  logic [0:pr_pkg::word_w-1] sr,
	input  logic [0:pr_pkg::word_w-1] rb,
	input  logic [0:pr_pkg::word_w-1] zp,
	output logic [0:pr_pkg::word_w-1] ki
);

	import pr_pkg::*;

	ki_src_t src;
	logic    zp_en;	// System bus carries data

	// ZP is open-collector, it only pulls the bus when it holds a word
	assign zp_en = |zp;

	always_comb begin
		case ({kia, kib})
			2'b10:   src = ki_rz;
			2'b01:   src = ki_sr;
			2'b11:   src = ki_rb;
			default: src = zp_en ? ki_zp : ki_none;	// No register source
		endcase
	end

	always_comb begin
		case (src)
			ki_rz:   ki = rz;
			ki_sr:   ki = sr;
			ki_rb:   ki = rb;
			ki_zp:   ki = zp;
			default: ki = '0;
		endcase
	end

endmodule

//--- rtl/pr.sv
/*
	P-R register unit
	User registers, R0, RB, NB/Q/BS, L-bus and KI-bus drivers
	Strobes are single-cycle enables sampled on the clock
*/

module pr #(
	parameter int cpu_number  = 0,	// 0 or 1
	parameter int awp_present = 0	// AWP may write ZMVC
) (
	input  logic                       __clk,
	input  logic                       rst,
	input  logic                       blr,		// Block registers, R0>>8 on L
	input  logic                       lpc,
	input  logic                       wa,
	input  logic                       rpc,
	input  logic                       ra,
	input  logic                       rb,
	input  logic                       rc,
	input  logic                       as2,
	input  logic                       w_r,
	input  logic                       strob1,
	input  logic                       strob2,
	input  logic [0:pr_pkg::word_w-1]  w,
	input  logic                       bar_nb,
	input  logic                       w_rba,
	input  logic                       w_rbb,
	input  logic                       w_rbc,
	input  logic                       rpn,
	input  logic                       bp_nb,
	input  logic                       pn_nb,
	input  logic                       q_nb,
	input  logic                       w_bar,
	input  logic                       zer_sp,
	input  logic                       clm,
	input  logic                       ustr0_fp,	// AWP flag write
	input  logic                       ust_leg,
	input  logic                       aryt,
	input  logic                       zs,
	input  logic                       carry,
	input  logic                       s_1,
	input  logic                       ust_z,
	input  logic                       ust_mc,
	input  logic                       s0,
	input  logic                       ust_v,
	input  logic                       clr_v,
	input  logic                       exy,
	input  logic                       ust_y,
	input  logic                       exx,
	input  logic                       ust_x,
	input  logic                       kia,
	input  logic                       kib,
	input  logic [0:pr_pkg::word_w-1]  bus_rz,
	input  logic [0:pr_pkg::word_w-1]  zp,
	input  logic [0:9]                 rs,
	output logic [0:pr_pkg::word_w-1]  l,
	output logic [0:3]                 dnb,
	output logic                       zgpn,
	output logic                       dpn,
	output logic                       dqb,
	output logic                       q,
	output logic                       zer,
	output logic [0:pr_pkg::flags_w-1] r0,
	output logic [0:pr_pkg::word_w-1]  bus_ki
);

	import pr_pkg::*;

	logic              strob_a, strob_b;
	logic              sel_user;		// R1-R7 addressed
	logic              w_r0;		// W->R0 through w_r
	logic              lr0;			// LPC load
	logic              fp;			// AWP load of ZMVC
	logic              w_zmvc, w_legy, lrp;
	logic              cleg;
	logic              vl, vg;
	logic [0:word_w-1] user_l, rb_q;
	logic [9:15]       user_byte;
	logic [0:3]        nb;
	logic              bs;
	l_src_t            l_src;

	assign strob_a  = strob1 & ~as2;
	assign strob_b  = strob2 & as2;
	assign sel_user = ra | rb | rc;

	assign lr0  = lpc & strob_a & wa;
	assign fp   = strob_a & (awp_present != 0) & ustr0_fp;
	assign w_r0 = (strob_a | strob_b) & w_r & ~sel_user;

	// Q protects the system flags from user writes
	assign w_zmvc = lr0 | (w_r0 & ~q) | fp;
	assign w_legy = lr0 | (w_r0 & ~q);
	assign lrp    = lr0 | w_r0;	// X and user byte share it

	assign cleg = strob_b & ust_leg;
	assign vl   = aryt ? s_1 : ~carry;
	assign vg   = aryt ? ~(zs | s_1) : (~zs & carry);

	always_comb begin
		if (blr) begin
			l_src = l_r0_high;
		end else if (sel_user && !(wa && rpc)) begin
			l_src = l_user;
		end else begin
			l_src = l_r0;	// Also RPC in WA
		end
	end

	// Open-collector style AND of all L drivers
	assign l = ((l_src == l_user)    ? user_l              : '1)
	         & ((l_src == l_r0)      ? {r0, user_byte}     : '1)
	         & ((l_src == l_r0_high) ? {8'd0, r0[0:7]}     : '1);

	assign zer = zer_sp | clm;

	regs u_regs (
		.__clk (__clk),
		.rst   (rst),
		.addr  ({rc, rb, ra}),
		.we    ((strob_a | strob_b) & w_r & sel_user),
		.w     (w),
		.l     (user_l)
	);

	rb u_rb (
		.__clk (__clk),
		.rst   (rst),
		.w     (w[10:15]),
		.w_rba (w_rba),
		.w_rbb (w_rbb),
		.w_rbc (w_rbc),
		.rb    (rb_q)
	);

	bar_regs #(
		.cpu_number (cpu_number)
	) u_bar_regs (
		.__clk  (__clk),
		.rst    (rst),
		.w_nb   (w[12:15]),
		.w_qbs  (w[10:11]),
		.w_bar  (w_bar),
		.strob1 (strob1),
		.clm    (clm),
		.zer    (zer),
		.bar_nb (bar_nb),
		.q_nb   (q_nb),
		.rpn    (rpn),
		.bp_nb  (bp_nb),
		.pn_nb  (pn_nb),
		.nb     (nb),
		.q      (q),
		.bs     (bs),
		.dnb    (dnb),
		.dqb    (dqb),
		.dpn    (dpn),
		.zgpn   (zgpn)
	);

	r0 u_r0 (
		.__clk     (__clk),
		.rst       (rst),
		.w         (w),
		.strob1    (strob1),
		.strob_b   (cleg),
		.w_zmvc    (w_zmvc),
		.w_legy    (w_legy),
		.w8_x      (lrp),
		.lrp       (lrp),
		.ust_z     (ust_z),
		.ust_mc    (ust_mc),
		.ust_v     (ust_v),
		.clr_v     (clr_v),
		.ust_y     (ust_y),
		.ust_x     (ust_x),
		.zs        (zs),
		.s0        (s0),
		.s_1       (s_1),
		.carry     (carry),
		.vl        (vl),
		.vg        (vg),
		.exy       (exy),
		.exx       (exx),
		.zer       (zer),
		.flags     (r0),
		.user_byte (user_byte)
	);

	bus_ki u_bus_ki (
		.kia (kia),
		.kib (kib),
		.rz  (bus_rz),
		.sr  ({rs, q, bs, nb}),	// Status word for the KI bus
		.rb  (rb_q),
		.zp  (zp),
		.ki  (bus_ki)
	);

endmodule

//--- test/pr_assertions.sv
/*
	Bus and flag invariants of the P-R register unit
	Bound into pr, checked on every rising clock edge
*/

module pr_assertions (
	input logic                      __clk,
	input logic                      rst,
	input logic                      bar_nb,
	input logic [0:3]                dnb,
	input logic                      zer,
	input logic                      q,
	input logic                      kia,
	input logic                      kib,
	input logic [0:pr_pkg::word_w-1] zp,
	input logic [0:pr_pkg::word_w-1] bus_ki
);

	timeunit 1ns;
	timeprecision 100ps;

	dnb_gated: assert property (@(posedge __clk) disable iff (rst)
			!bar_nb |-> dnb == '0)	// NB driver off unless asked
		else $error("dnb driven while bar_nb is low");

	q_cleared: assert property (@(posedge __clk) disable iff (rst)
			zer |=> !q)
		else $error("q still set one cycle after zer");

	// Open-collector ZP pulls the idle bus only when it carries a word
	ki_idle: assert property (@(posedge __clk) disable iff (rst)
			(!kia && !kib && zp == '0) |-> bus_ki == '0)
		else $error("KI bus not zero with no source selected");

endmodule

//--- test/pr_tb.sv
/*
	Testbench for the P-R register unit
	Replays operations from the vector file, checks L, KI, R0 and the bus drivers
*/

module pr_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import pr_pkg::*;

	localparam int cpu_id = 0;	// Processor number of the DUT

	logic                __clk, rst;
	logic                blr, lpc, wa, rpc, ra, rb, rc, as2, w_r, strob1, strob2;
	logic [0:word_w-1]   w;
	logic                bar_nb, w_rba, w_rbb, w_rbc, rpn, bp_nb, pn_nb, q_nb, w_bar;
	logic                zer_sp, clm, ustr0_fp, ust_leg, aryt, zs, carry, s_1;
	logic                ust_z, ust_mc, s0, ust_v, clr_v, exy, ust_y, exx, ust_x;
	logic                kia, kib;
	logic [0:word_w-1]   bus_rz, zp;
	logic [0:9]          rs;
	logic [0:word_w-1]   l, bus_ki;
	logic [0:3]          dnb;
	logic                zgpn, dpn, dqb, q, zer;
	logic [0:flags_w-1]  r0;

	string               ops[$];	// Mnemonic per vector line
	logic [0:word_w-1]   arg_a[$], arg_b[$], arg_e[$];
	logic [0:word_w-1]   shadow [1:user_regs];	// Last word written to each user register
	logic [31:0]         seed = 32'h2093_db33;
	int                  errors = 0;
	int                  checks = 0;
	int                  cycles = 0;
	int                  limit = 0;	// Zero until the vectors are loaded

	pr #(
		.cpu_number  (cpu_id),
		.awp_present (1)
	) pr_i (.*);

	bind pr pr_assertions u_pr_assertions (
		.__clk  (__clk),
		.rst    (rst),
		.bar_nb (bar_nb),
		.dnb    (dnb),
		.zer    (zer),
		.q      (q),
		.kia    (kia),
		.kib    (kib),
		.zp     (zp),
		.bus_ki (bus_ki)
	);

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk;	// 4 ns period
	end

	always @(posedge __clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: the vectors did not finish within %0d cycles", limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// L source implied by the current selection inputs
	function automatic l_src_t l_source();
		if (blr) begin
			return l_r0_high;
		end else if ({rc, rb, ra} != 3'd0 && !(wa && rpc)) begin
			return l_user;
		end
		return l_r0;
	endfunction

	// Names of the flags that differ, for the error line
	function automatic string flag_diff(input logic [0:flags_w-1] a,
			input logic [0:flags_w-1] b);
		string s;
		flag_t f;
		s = "flags";
		for (int i = 0; i < flags_w; i++) begin
			f = flag_t'(4'(i));
			if (a[i] !== b[i]) begin
				s = {s, " ", f.name()};
			end
		end
		return s;
	endfunction

	task automatic compare_word(input string name, input logic [0:word_w-1] exp,
			input logic [0:word_w-1] act);
		checks++;
		assert (act === exp) else begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic drop_strobes();
		{strob1, strob2, w_r, lpc, w_bar, w_rba, w_rbb, w_rbc} <= '0;
		{ust_z, ust_mc, ust_v, clr_v, ust_leg, ust_y, ust_x} <= '0;
		{zer_sp, clm, ustr0_fp} <= '0;
	endtask

	task automatic idle_inputs();
		drop_strobes();
		{blr, wa, rpc, ra, rb, rc, as2} <= '0;
		{kia, kib, bar_nb, q_nb, rpn, bp_nb, pn_nb} <= '0;
		{aryt, zs, carry, s_1, s0, exy, exx} <= '0;
		w <= '0;
		bus_rz <= '0;
		zp <= '0;
		rs <= '0;
	endtask

	task automatic load_vectors(output bit ok);
		int                fd;
		int                n;
		string             line, op;
		logic [0:word_w-1] a, b, e;
		fd = $fopen("test/pr_testdata.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#") begin	// Skip column notes
					n = $sscanf(line, "%s %h %h %h", op, a, b, e);
					if (n == 4) begin
						ops.push_back(op);
						arg_a.push_back(a);
						arg_b.push_back(b);
						arg_e.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input string op, input logic [0:word_w-1] a,
			input logic [0:word_w-1] b, input logic [0:word_w-1] e);
		logic [0:word_w-1] data;
		logic              pn_rx;
		data = b;
		pn_rx = 1'b0;
		@(posedge __clk);
		idle_inputs();
		{rc, rb, ra} <= a[13:15];	// Register address
		w <= b;
		if (op == "wreg" || op == "rand" || op == "wr0") begin
			if (op == "rand") begin
				seed = xorshift32(seed);	// Filler word
				data = seed[15:0];
				w <= data;
			end
			w_r <= 1'b1;
			strob1 <= 1'b1;
		end else if (op == "lpc") begin
			{wa, lpc, strob1} <= 3'b111;	// R0 load in state WA
		end else if (op == "rdl") begin
			{rpc, wa, blr} <= b[13:15];
		end else if (op == "flag") begin
			{strob1, strob2, as2} <= 3'b111;	// Both strobes for LEG too
			{ust_x, ust_y, ust_leg, clr_v, ust_v, ust_mc, ust_z} <= a[9:15];
			{exx, exy, aryt, carry, s_1, s0, zs} <= b[9:15];
		end else if (op == "sys") begin
			{clm, zer_sp, w_bar, q_nb, bar_nb} <= a[11:15];
			seed = xorshift32(seed);
			pn_rx = seed[0];	// Random processor number on the bus
			rpn <= pn_rx;
			strob1 <= 1'b1;
		end else if (op == "rb") begin
			{w_rba, w_rbb, w_rbc} <= a[13:15];
			{kia, kib} <= 2'b11;	// Read back through RB
		end else if (op == "ki") begin
			{kib, kia} <= a[14:15];
			bus_rz <= b;
			zp <= b;
			rs <= b[0:9];
		end
		@(negedge __clk);	// Strobes still high
		if (op == "sys") begin
			// zer follows zer_sp or clm, zgpn marks a PN equal to our number
			compare_word("sys zer", {15'd0, a[11] | a[12]}, {15'd0, zer});
			compare_word("sys zgpn", {15'd0, pn_rx == 1'(cpu_id)}, {15'd0, zgpn});
		end
		@(posedge __clk);	// Write edge
		drop_strobes();
		@(negedge __clk);
		if (op == "wreg" || op == "rand") begin
			shadow[a[13:15]] = data;
			compare_word({op, " ", l_source().name()}, data, l);
		end else if (op == "rdreg") begin
			compare_word({op, " ", l_source().name()}, shadow[a[13:15]], l);
		end else if (op == "lpc" || op == "rdl") begin
			compare_word({op, " ", l_source().name()}, e, l);
		end else if (op == "flag" || op == "wr0") begin
			compare_word(flag_diff(e[7:15], r0), e, {7'd0, r0});
		end else if (op == "sys") begin
			compare_word("sys drivers", e, {10'd0, dpn, dqb, dnb});
		end else if (op == "rb" || op == "ki") begin
			compare_word({op, " bus"}, e, bus_ki);
		end else begin
			$display("Unknown operation %s in the vector file", op);
			errors++;
		end
	endtask

	initial begin
		bit ok;
		rst <= 1'b1;
		idle_inputs();
		load_vectors(ok);
		if (!ok) begin
			$display("Cannot open the vector file test/pr_testdata.txt");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			limit = 20 * ops.size();
			repeat (8) @(posedge __clk);
			rst <= 1'b0;
			for (int i = 0; i < ops.size(); i++) begin
				run_op(ops[i], arg_a[i], arg_b[i], arg_e[i]);
			end
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

//--- test/pr_testdata.txt
# Columns: op a b expected, hex. rdl b: 1 blr 2 wa 4 rpc. flag a: updates, b: ALU inputs
# sys a: 1 bar_nb 2 q_nb 4 w_bar 8 zer_sp 10 clm. rb a: 1 c 2 b 4 a. ki a: 0 zp 1 rz 2 sr 3 rb
wreg 1 a5a5 a5a5
wreg 2 5a5a 5a5a
wreg 3 0f0f 0f0f
wreg 4 f0f0 f0f0
wreg 5 1234 1234
wreg 6 8001 8001
wreg 7 7ffe 7ffe
rand 3 0000 0000
rdreg 1 0000 0000
rdreg 3 0000 0000
rdreg 7 0000 0000
lpc 0 b5a7 b5a7
rdl 0 0 b5a7
rdl 0 1 00b5
rdl 3 6 b5a7
rdl 2 4 5a5a
lpc 0 0000 0000
flag 01 01 0100
flag 02 0a 01a0
flag 04 02 01e0
flag 04 06 01e0
flag 08 00 01a0
flag 10 14 01b0
flag 10 08 01a4
flag 10 11 01a8
flag 20 20 01aa
flag 40 40 01ab
flag 41 00 00aa
wr0 0 ff80 01ff
rb 1 002c b000
rb 2 0015 b540
rb 4 003a b57a
ki 1 1357 1357
ki 0 2468 2468
ki 0 0000 0000
sys 07 003a 001a
sys 00 0000 0000
sys 01 0000 000a
sys 02 0000 0010
ki 2 ffc0 fffa
wr0 0 007f 01fe
rdl 0 0 ff7f
sys 0b 0000 000a
rdl 0 0 ff00
ki 2 0000 001a
sys 13 0000 0000
ki 2 0000 0000

//--- sources.f
rtl/pr_pkg.sv
rtl/regs.sv
rtl/rb.sv
rtl/bar_regs.sv
rtl/r0.sv
rtl/bus_ki.sv
rtl/pr.sv
test/pr_assertions.sv
test/pr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the register unit testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module pr_tb -o pr_sim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/pr_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
